//--- Makefile
TOP = tb_execute_core

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

//--- cb_types_pkg.sv
// completion buffer types for slot tags and occupancy
`include "exec_defines.svh"

package cb_types_pkg;

  // slot tag handed out at issue
  typedef logic [$clog2(`CB_ENTRIES)-1:0] cb_index_t;

  // one bit wider so a full buffer can be counted
  typedef logic [$clog2(`CB_ENTRIES):0] cb_count_t;

endpackage

//--- commit_unit.sv
// commit stage: retires the head slot in program order, drives register write and redirect
`timescale 1ns/1ps

module commit_unit import isa_types_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      head_ready,
  input  reg_addr_t head_rd,
  input  logic      head_wen,
  input  word_t     head_data,
  input  logic      head_redirect,
  input  word_t     head_redirect_addr,
  output logic      retire,
  output logic      retire_valid,
  output reg_addr_t retire_rd,
  output logic      retire_wen,
  output word_t     retire_data,
  output logic      redirect,
  output word_t     redirect_addr
);

  // redirect is high for exactly the squash cycle, so it holds off the next retire
  assign retire = head_ready && !redirect;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      retire_valid <= 1'b0;
      retire_wen   <= 1'b0;
      redirect     <= 1'b0;
    end else begin
      retire_valid <= retire;
      retire_wen   <= retire && head_wen;
      redirect     <= retire && head_redirect;
    end
  end

  always_ff @(posedge CLK) begin
    if (retire) begin
      retire_rd     <= head_rd;
      retire_data   <= head_data;
      redirect_addr <= head_redirect_addr;
    end
  end

  a_retire_cause: assert property (@(posedge CLK) disable iff (!nRST)
    (retire_valid || redirect) |-> $past(retire))
    else $error("retire_valid or redirect without a retire");

endmodule

//--- compile.f
+incdir+.
isa_types_pkg.sv
cb_types_pkg.sv
exec_units.sv
completion_buffer.sv
commit_unit.sv
execute_core.sv
tb_clock_gen.sv
tb_execute_core.sv

//--- completion_buffer.sv
// completion buffer: tags issued instructions, collects results out of order, exposes the head
`timescale 1ns/1ps
`include "exec_defines.svh"

module completion_buffer import isa_types_pkg::*, cb_types_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      issue_valid,
  input  logic      int_done,
  input  cb_index_t int_index,
  input  reg_addr_t int_rd,
  input  logic      int_wen,
  input  word_t     int_data,
  input  logic      int_redirect,
  input  word_t     int_redirect_addr,
  input  logic      mul_done,
  input  cb_index_t mul_index,
  input  reg_addr_t mul_rd,
  input  word_t     mul_data,
  input  logic      retire,
  output cb_index_t alloc_index,
  output logic      full,
  output logic      head_ready,
  output reg_addr_t head_rd,
  output logic      head_wen,
  output word_t     head_data,
  output logic      head_redirect,
  output word_t     head_redirect_addr
);

  localparam int DEPTH = `CB_ENTRIES;

  cb_index_t        head_ptr;
  cb_index_t        tail_ptr;
  cb_count_t        count;
  logic             alloc;
  logic [DEPTH-1:0] slot_busy;
  logic [DEPTH-1:0] slot_done;
  reg_addr_t        slot_rd    [DEPTH];
  logic             slot_wen   [DEPTH];
  word_t            slot_data  [DEPTH];
  logic             slot_redir [DEPTH];
  word_t            slot_raddr [DEPTH];

  assign full        = count == cb_count_t'(DEPTH);
  assign alloc       = issue_valid && !full;
  assign alloc_index = tail_ptr;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      head_ptr  <= '0;
      tail_ptr  <= '0;
      count     <= '0;
      slot_busy <= '0;
      slot_done <= '0;
    end else begin
      // a fresh slot starts incomplete
      if (alloc) begin
        tail_ptr            <= tail_ptr + 1'b1;
        slot_busy[tail_ptr] <= 1'b1;
        slot_done[tail_ptr] <= 1'b0;
      end
      if (retire) begin
        head_ptr            <= head_ptr + 1'b1;
        slot_busy[head_ptr] <= 1'b0;
      end
      if (int_done) begin
        slot_done[int_index] <= 1'b1;
      end
      if (mul_done) begin
        slot_done[mul_index] <= 1'b1;
      end
      count <= count + cb_count_t'(alloc) - cb_count_t'(retire);
    end
  end

  always_ff @(posedge CLK) begin
    if (int_done) begin
      slot_rd[int_index]    <= int_rd;
      slot_wen[int_index]   <= int_wen;
      slot_data[int_index]  <= int_data;
      slot_redir[int_index] <= int_redirect;
      slot_raddr[int_index] <= int_redirect_addr;
    end
    // products always write rd and never redirect
    if (mul_done) begin
      slot_rd[mul_index]    <= mul_rd;
      slot_wen[mul_index]   <= 1'b1;
      slot_data[mul_index]  <= mul_data;
      slot_redir[mul_index] <= 1'b0;
    end
  end

  assign head_ready         = slot_busy[head_ptr] && slot_done[head_ptr];
  assign head_rd            = slot_rd[head_ptr];
  assign head_wen           = slot_wen[head_ptr];
  assign head_data          = slot_data[head_ptr];
  assign head_redirect      = slot_redir[head_ptr];
  assign head_redirect_addr = slot_raddr[head_ptr];

  a_no_issue_full: assert property (@(posedge CLK) disable iff (!nRST)
    issue_valid |-> !full)
    else $error("issue while completion buffer full");

  a_alloc_write: assert property (@(posedge CLK) disable iff (!nRST)
    (int_done |-> slot_busy[int_index]) and (mul_done |-> slot_busy[mul_index]))
    else $error("result written to an unallocated slot");

  a_port_clash: assert property (@(posedge CLK) disable iff (!nRST)
    (int_done && mul_done) |-> (int_index != mul_index))
    else $error("int and mul ports wrote slot %0d together", int_index);

endmodule

//--- exec_defines.svh
// widths, buffer depth and multiplier latency, included by the execute packages and RTL
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// data path word
`define WORD_W 32

// architectural register address
`define REG_ADDR_W 5

// completion buffer slots, a power of two
`define CB_ENTRIES 8

// cycles from multiply issue to result write
`define MUL_LATENCY 3

`endif

//--- exec_units.sv
// producer of the execute stage: integer, branch and jump results plus the tagged multiplier
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_units import isa_types_pkg::*, cb_types_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      issue_valid,
  input  fu_sel_t   issue_fu,
  input  alu_op_t   issue_alu_op,
  input  br_op_t    issue_br_op,
  input  logic      issue_prediction,
  input  reg_addr_t issue_rd,
  input  word_t     issue_pc,
  input  word_t     issue_port_a,
  input  word_t     issue_port_b,
  input  word_t     issue_imm,
  input  cb_index_t alloc_index,
  output logic      int_done,
  output cb_index_t int_index,
  output reg_addr_t int_rd,
  output logic      int_wen,
  output word_t     int_data,
  output logic      int_redirect,
  output word_t     int_redirect_addr,
  output logic      mul_done,
  output cb_index_t mul_index,
  output reg_addr_t mul_rd,
  output word_t     mul_data
);

  localparam int LAT = `MUL_LATENCY;

  word_t     alu_result;
  word_t     pc_plus4;
  word_t     br_target;
  word_t     jump_target;
  logic      br_taken;
  logic      is_int;
  logic      is_mul;
  logic      int_wen_d;
  word_t     int_data_d;
  logic      int_redirect_d;
  word_t     int_raddr_d;
  logic      mul_vld    [LAT];
  cb_index_t mul_idx_q  [LAT];
  reg_addr_t mul_rd_q   [LAT];
  word_t     mul_prod_q [LAT];

  assign is_mul      = issue_valid && (issue_fu == FU_MUL);
  assign is_int      = issue_valid && (issue_fu != FU_MUL);
  assign pc_plus4    = issue_pc + word_t'(4);
  assign br_target   = issue_pc + issue_imm;
  // jalr style target, bit 0 forced low
  assign jump_target = (issue_port_a + issue_imm) & ~word_t'(1);

  always_comb begin
    case (issue_alu_op)
      ADD:     alu_result = issue_port_a + issue_port_b;
      SUB:     alu_result = issue_port_a - issue_port_b;
      AND:     alu_result = issue_port_a & issue_port_b;
      OR:      alu_result = issue_port_a | issue_port_b;
      XOR:     alu_result = issue_port_a ^ issue_port_b;
      SLL:     alu_result = issue_port_a << issue_port_b[4:0];
      SRL:     alu_result = issue_port_a >> issue_port_b[4:0];
      SRA:     alu_result = $signed(issue_port_a) >>> issue_port_b[4:0];
      SLT:     alu_result = word_t'($signed(issue_port_a) < $signed(issue_port_b));
      SLTU:    alu_result = word_t'(issue_port_a < issue_port_b);
      default: alu_result = '0;
    endcase
  end

  always_comb begin
    case (issue_br_op)
      BEQ:     br_taken = issue_port_a == issue_port_b;
      BNE:     br_taken = issue_port_a != issue_port_b;
      BLT:     br_taken = $signed(issue_port_a) < $signed(issue_port_b);
      BGE:     br_taken = $signed(issue_port_a) >= $signed(issue_port_b);
      BLTU:    br_taken = issue_port_a < issue_port_b;
      BGEU:    br_taken = issue_port_a >= issue_port_b;
      default: br_taken = 1'b0;
    endcase
  end

  // plain alu op unless the unit select says branch or jump
  always_comb begin
    int_wen_d      = 1'b1;
    int_data_d     = alu_result;
    int_redirect_d = 1'b0;
    int_raddr_d    = pc_plus4;
    case (issue_fu)
      FU_BRANCH: begin
        int_wen_d      = 1'b0;
        int_redirect_d = br_taken != issue_prediction;
        int_raddr_d    = br_taken ? br_target : pc_plus4;
      end
      FU_JUMP: begin
        int_data_d     = pc_plus4;
        int_redirect_d = 1'b1;
        int_raddr_d    = jump_target;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      int_done <= 1'b0;
      for (int i = 0; i < LAT; i++) begin
        mul_vld[i] <= 1'b0;
      end
    end else begin
      int_done   <= is_int;
      mul_vld[0] <= is_mul;
      for (int i = 1; i < LAT; i++) begin
        mul_vld[i] <= mul_vld[i-1];
      end
    end
  end

  always_ff @(posedge CLK) begin
    int_index         <= alloc_index;
    int_rd            <= issue_rd;
    int_wen           <= int_wen_d;
    int_data          <= int_data_d;
    int_redirect      <= int_redirect_d;
    int_redirect_addr <= int_raddr_d;
    // tag and rd ride along with the product
    mul_idx_q[0]  <= alloc_index;
    mul_rd_q[0]   <= issue_rd;
    mul_prod_q[0] <= issue_port_a * issue_port_b;
    for (int i = 1; i < LAT; i++) begin
      mul_idx_q[i]  <= mul_idx_q[i-1];
      mul_rd_q[i]   <= mul_rd_q[i-1];
      mul_prod_q[i] <= mul_prod_q[i-1];
    end
  end

  assign mul_done  = mul_vld[LAT-1];
  assign mul_index = mul_idx_q[LAT-1];
  assign mul_rd    = mul_rd_q[LAT-1];
  assign mul_data  = mul_prod_q[LAT-1];

  a_mul_latency: assert property (@(posedge CLK) disable iff (!nRST)
    is_mul |-> ##LAT mul_done)
    else $error("multiply result not written %0d cycles after issue", LAT);

endmodule

//--- execute_core.sv
// top of the execute and completion path; connects producer, completion buffer and commit
`timescale 1ns/1ps

module execute_core import isa_types_pkg::*, cb_types_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      issue_valid,
  input  fu_sel_t   issue_fu,
  input  alu_op_t   issue_alu_op,
  input  br_op_t    issue_br_op,
  input  logic      issue_prediction,
  input  reg_addr_t issue_rd,
  input  word_t     issue_pc,
  input  word_t     issue_port_a,
  input  word_t     issue_port_b,
  input  word_t     issue_imm,
  output logic      full,
  output logic      retire_valid,
  output reg_addr_t retire_rd,
  output logic      retire_wen,
  output word_t     retire_data,
  output logic      redirect,
  output word_t     redirect_addr
);

  cb_index_t alloc_index;
  logic      int_done;
  cb_index_t int_index;
  reg_addr_t int_rd;
  logic      int_wen;
  word_t     int_data;
  logic      int_redirect;
  word_t     int_redirect_addr;
  logic      mul_done;
  cb_index_t mul_index;
  reg_addr_t mul_rd;
  word_t     mul_data;
  logic      head_ready;
  reg_addr_t head_rd;
  logic      head_wen;
  word_t     head_data;
  logic      head_redirect;
  word_t     head_redirect_addr;
  logic      retire;

  exec_units i_exec_units (.*);

  completion_buffer i_completion_buffer (.*);

  commit_unit i_commit_unit (.*);

endmodule

//--- isa_types_pkg.sv
// instruction-level types shared by the execute units, the completion buffer and commit
`include "exec_defines.svh"

package isa_types_pkg;

  typedef logic [`WORD_W-1:0]     word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // which unit executes the instruction
  typedef enum logic [1:0] {
    FU_ALU,
    FU_BRANCH,
    FU_JUMP,
    FU_MUL
  } fu_sel_t;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA, SLT, SLTU
  } alu_op_t;

  // branch compares, signed and unsigned
  typedef enum logic [2:0] {
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU
  } br_op_t;

endpackage

//--- tb_clock_gen.sv
// testbench clock source, 8 ns period, with active low reset held for the first 8 cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // release just after an edge so the design leaves reset cleanly
  initial begin
    nRST = 1'b0;
    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;
  end

endmodule

//--- tb_execute_core.sv
// testbench for execute_core that issues instruction streams and checks retires in program order
`timescale 1ns/1ps
`include "exec_defines.svh"

module tb_execute_core import isa_types_pkg::*; ();

  localparam int    N_TESTS         = 5;
  localparam int    CYCLES_PER_TEST = 200;
  localparam int    SEED            = 51;
  localparam word_t SIGN            = word_t'(1) << (`WORD_W - 1);

  // one retire as the reference model predicts it
  typedef struct packed {
    reg_addr_t rd;
    logic      wen;
    word_t     data;
    logic      redir;
    word_t     raddr;
  } exp_t;

  logic      CLK;
  logic      nRST;
  logic      issue_valid;
  fu_sel_t   issue_fu;
  alu_op_t   issue_alu_op;
  br_op_t    issue_br_op;
  logic      issue_prediction;
  reg_addr_t issue_rd;
  word_t     issue_pc;
  word_t     issue_port_a;
  word_t     issue_port_b;
  word_t     issue_imm;
  logic      full;
  logic      retire_valid;
  reg_addr_t retire_rd;
  logic      retire_wen;
  word_t     retire_data;
  logic      redirect;
  word_t     redirect_addr;
  exp_t      exp_q [$];
  exp_t      cur;
  exp_t      got;
  logic      chk;
  int        seed;
  int        errors;
  int        n_issued;
  int        n_retired;
  int        n_tests;

  tb_clock_gen i_clock_gen (.CLK, .nRST);

  execute_core i_execute_core (.*);

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  // signed compare done by flipping the sign bits
  function automatic logic lt_signed(word_t a, word_t b);
    return (a ^ SIGN) < (b ^ SIGN);
  endfunction

  function automatic word_t alu_ref(alu_op_t op, word_t a, word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ADD:     return a + b;
      SUB:     return a + ~b + word_t'(1);
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << sh;
      SRL:     return a >> sh;
      SRA:     return (a >> sh) | ((a & SIGN) != 0 ? ~({`WORD_W{1'b1}} >> sh) : '0);
      SLT:     return lt_signed(a, b) ? word_t'(1) : '0;
      SLTU:    return (a < b) ? word_t'(1) : '0;
      default: return '0;
    endcase
  endfunction

  function automatic logic branch_taken(br_op_t op, word_t a, word_t b);
    case (op)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return lt_signed(a, b);
      BGE:     return !lt_signed(a, b);
      BLTU:    return a < b;
      BGEU:    return !(a < b);
      default: return 1'b0;
    endcase
  endfunction

  task automatic report_value(string name, word_t exp_val, word_t got_val);
    $display("FAIL t=%0t %s expected %h got %h", $time, name, exp_val, got_val);
    errors++;
  endtask

  task automatic report_error(string msg);
    $display("ERROR t=%0t %s", $time, msg);
    errors++;
  endtask

  // drives one instruction for a single cycle and queues its expected retire
  task automatic issue_instr(fu_sel_t fu, alu_op_t aop, br_op_t bop, logic pred,
                             word_t a, word_t b, word_t imm);
    exp_t  e;
    word_t pc;
    logic  taken;
    pc      = rand_word() & ~word_t'(3);
    taken   = branch_taken(bop, a, b);
    e.rd    = reg_addr_t'(rand_word());
    e.wen   = fu != FU_BRANCH;
    e.data  = alu_ref(aop, a, b);
    e.redir = 1'b0;
    e.raddr = '0;
    case (fu)
      FU_MUL: e.data = a * b;
      FU_JUMP: begin
        e.data  = pc + word_t'(4);
        e.redir = 1'b1;
        e.raddr = (a + imm) & ~word_t'(1);
      end
      FU_BRANCH: begin
        e.redir = taken != pred;
        e.raddr = taken ? pc + imm : pc + word_t'(4);
      end
      default: ;
    endcase
    exp_q.push_back(e);
    issue_valid      = 1'b1;
    issue_fu         = fu;
    issue_alu_op     = aop;
    issue_br_op      = bop;
    issue_prediction = pred;
    issue_rd         = e.rd;
    issue_pc         = pc;
    issue_port_a     = a;
    issue_port_b     = b;
    issue_imm        = imm;
    @(posedge CLK);
    n_issued++;
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic drain();
    while (n_retired < n_issued) @(posedge CLK);
    repeat (2) @(posedge CLK);
    #1;
  endtask

  task automatic finish_test(string name);
    n_tests++;
    $display("test %0d %-26s retired %0d, errors %0d", n_tests, name, n_retired, errors);
  endtask

  // capture each retire at the falling edge for the checks at the next rising edge
  always @(negedge CLK) begin
    chk = 1'b0;
    if (nRST) begin
      if (retire_valid) begin
        n_retired++;
        if (exp_q.size() == 0) begin
          report_error("retire seen with no instruction outstanding");
        end else begin
          cur = exp_q.pop_front();
          got = '{retire_rd, retire_wen, retire_data, redirect, redirect_addr};
          chk = 1'b1;
        end
      end else if (redirect) begin
        report_error("redirect raised without a retire");
      end
      // occupancy follows issues minus retires
      assert (full == ((n_issued - n_retired) == `CB_ENTRIES))
        else report_value("full", word_t'(n_issued - n_retired == `CB_ENTRIES), word_t'(full));
    end
  end

  a_rd: assert property (@(posedge CLK) chk |-> got.rd == cur.rd)
    else report_value("retire_rd", word_t'(cur.rd), word_t'(got.rd));
  a_wen: assert property (@(posedge CLK) chk |-> got.wen == cur.wen)
    else report_value("retire_wen", word_t'(cur.wen), word_t'(got.wen));
  a_data: assert property (@(posedge CLK) (chk && cur.wen) |-> got.data == cur.data)
    else report_value("retire_data", cur.data, got.data);
  a_redir: assert property (@(posedge CLK) chk |-> got.redir == cur.redir)
    else report_value("redirect", word_t'(cur.redir), word_t'(got.redir));
  a_raddr: assert property (@(posedge CLK) (chk && cur.redir) |-> got.raddr == cur.raddr)
    else report_value("redirect_addr", cur.raddr, got.raddr);

  initial begin
    word_t a;
    seed             = SEED;
    errors           = 0;
    n_issued         = 0;
    n_retired        = 0;
    n_tests          = 0;
    chk              = 1'b0;
    issue_valid      = 1'b0;
    issue_fu         = FU_ALU;
    issue_alu_op     = ADD;
    issue_br_op      = BEQ;
    issue_prediction = 1'b0;
    issue_rd         = '0;
    issue_pc         = '0;
    issue_port_a     = '0;
    issue_port_b     = '0;
    issue_imm        = '0;
    wait (nRST === 1'b1);
    assert (!full && !retire_valid && !redirect)
      else report_error("full, retire_valid or redirect high after reset");
    // every alu op twice with random operands
    for (int k = 0; k < 20; k++) begin
      issue_instr(FU_ALU, alu_op_t'(k % 10), BEQ, 1'b0, rand_word(), rand_word(), '0);
    end
    drain();
    finish_test("random alu ops");
    // second multiply enters while the first is still in flight
    issue_instr(FU_MUL, ADD, BEQ, 1'b0, rand_word(), rand_word(), '0);
    issue_instr(FU_ALU, alu_op_t'(rand_word() % 10), BEQ, 1'b0, rand_word(), rand_word(), '0);
    issue_instr(FU_MUL, ADD, BEQ, 1'b0, rand_word(), rand_word(), '0);
    repeat (3) begin
      issue_instr(FU_ALU, alu_op_t'(rand_word() % 10), BEQ, 1'b0, rand_word(), rand_word(), '0);
    end
    drain();
    finish_test("multiply ahead of alu ops");
    // each compare on equal operands and then on random ones
    for (int k = 0; k < 12; k++) begin
      a = rand_word();
      issue_instr(FU_BRANCH, ADD, br_op_t'(k / 2), 1'(rand_word()), a,
                  (k % 2 == 0) ? a : rand_word(), rand_word());
      drain();
    end
    finish_test("branches");
    repeat (4) begin
      issue_instr(FU_JUMP, ADD, BEQ, 1'b0, rand_word(), rand_word(), rand_word());
      drain();
    end
    finish_test("jumps");
    repeat (8) begin
      issue_instr(FU_MUL, ADD, BEQ, 1'b0, rand_word(), rand_word(), '0);
    end
    drain();
    finish_test("back to back multiplies");
    $display("tests %0d, issued %0d, retired %0d, errors %0d",
             n_tests, n_issued, n_retired, errors);
    if (errors == 0 && exp_q.size() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    repeat (N_TESTS * CYCLES_PER_TEST) @(posedge CLK);
    $display("watchdog expired after %0d cycles", N_TESTS * CYCLES_PER_TEST);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
